//--- source/hps_ext_pkg.sv
`default_nettype none

package hps_ext_pkg;

	// one word on the host extension bus
	typedef logic [15:0] io_word_t;
	// byte address and data word on the memory bus
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	// dma request lines in, status pulse lines out
	typedef logic [1:0] dma_line_t;

	// command codes sent as the first word of a transfer
	typedef enum logic [15:0] {
		cmd_dma_write  = 16'h0061,
		cmd_dma_read   = 16'h0062,
		cmd_dma_status = 16'h0063
	} ext_cmd_e;

	// header covers the two address words, stream covers everything after them
	typedef enum logic [1:0] {
		idle,
		header,
		stream,
		wait_read
	} ext_state_e;

	// everything a master drives on an AXI4-Lite port
	typedef struct packed {
		addr_t      awaddr;
		logic       awvalid;
		data_t      wdata;
		logic [3:0] wstrb;
		logic       wvalid;
		logic       bready;
		addr_t      araddr;
		logic       arvalid;
		logic       rready;
	} axil_req_t;

	// everything a slave drives back
	typedef struct packed {
		logic       awready;
		logic       wready;
		logic [1:0] bresp;
		logic       bvalid;
		logic       arready;
		data_t      rdata;
		logic [1:0] rresp;
		logic       rvalid;
	} axil_rsp_t;

endpackage

`default_nettype wire

//--- source/hps_ext.sv
`default_nettype none

module hps_ext (
	input  wire                      clk_sys,
	input  wire                      rst_n,
	input  hps_ext_pkg::io_word_t    io_din,
	input  wire                      io_strobe,
	input  wire                      io_enable,
	output hps_ext_pkg::io_word_t    io_dout,
	output logic                     dout_en,
	output logic                     busy,
	input  hps_ext_pkg::dma_line_t   dma_req,
	output hps_ext_pkg::dma_line_t   dma_status,
	output hps_ext_pkg::axil_req_t   host_req,
	input  hps_ext_pkg::axil_rsp_t   host_rsp
);

	hps_ext_pkg::ext_state_e state;
	// counts the command word and the two address words, then saturates
	logic [1:0]                      word_cnt;
	hps_ext_pkg::io_word_t           cmd;
	// low or high half of the current 32-bit word
	logic                            hilo;
	hps_ext_pkg::addr_t              addr;
	hps_ext_pkg::io_word_t           wdata_lo;
	hps_ext_pkg::data_t              wdata;
	hps_ext_pkg::io_word_t           rd_hi;
	logic                            awvalid;
	logic                            wvalid;
	logic                            arvalid;

	// responses are always taken at once, so busy alone throttles the host
	assign host_req.awaddr  = addr;
	assign host_req.awvalid = awvalid;
	assign host_req.wdata   = wdata;
	assign host_req.wstrb   = 4'hf;
	assign host_req.wvalid  = wvalid;
	assign host_req.bready  = 1'b1;
	assign host_req.araddr  = addr;
	assign host_req.arvalid = arvalid;
	assign host_req.rready  = 1'b1;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state      <= hps_ext_pkg::idle;
			word_cnt   <= '0;
			cmd        <= '0;
			hilo       <= 1'b0;
			addr       <= '0;
			wdata_lo   <= '0;
			wdata      <= '0;
			rd_hi      <= '0;
			io_dout    <= '0;
			dout_en    <= 1'b0;
			busy       <= 1'b0;
			dma_status <= '0;
			awvalid    <= 1'b0;
			wvalid     <= 1'b0;
			arvalid    <= 1'b0;
		end else begin
			// the status lines only pulse for the cycle after a strobe
			dma_status <= '0;

			// channel handshakes run on even if the host drops io_enable
			if (awvalid && host_rsp.awready) begin
				awvalid <= 1'b0;
			end
			if (wvalid && host_rsp.wready) begin
				wvalid <= 1'b0;
			end
			if (arvalid && host_rsp.arready) begin
				arvalid <= 1'b0;
			end
			// a finished write moves the block pointer to the next word
			if (host_rsp.bvalid) begin
				busy <= 1'b0;
				addr <= addr + 32'd4;
			end
			if (host_rsp.rvalid) begin
				busy  <= 1'b0;
				rd_hi <= host_rsp.rdata[31:16];
			end

			if (!io_enable) begin
				state    <= hps_ext_pkg::idle;
				word_cnt <= '0;
				hilo     <= 1'b0;
				io_dout  <= '0;
				dout_en  <= 1'b0;
			end else if (state == hps_ext_pkg::wait_read) begin
				// the low half is shown as soon as the read data is in
				if (host_rsp.rvalid) begin
					io_dout <= host_rsp.rdata[15:0];
					state   <= hps_ext_pkg::stream;
				end
			end else if (io_strobe) begin
				if (word_cnt != 2'd3) begin
					word_cnt <= word_cnt + 2'd1;
				end
				case (state)
					hps_ext_pkg::idle: begin
						cmd     <= io_din;
						hilo    <= 1'b0;
						io_dout <= '0;
						dout_en <= (io_din == hps_ext_pkg::cmd_dma_write) ||
							(io_din == hps_ext_pkg::cmd_dma_read) ||
							(io_din == hps_ext_pkg::cmd_dma_status);
						// only the block commands carry an address
						if ((io_din == hps_ext_pkg::cmd_dma_write) ||
							(io_din == hps_ext_pkg::cmd_dma_read)) begin
							state <= hps_ext_pkg::header;
						end else begin
							state <= hps_ext_pkg::stream;
						end
					end
					hps_ext_pkg::header: begin
						if (word_cnt == 2'd1) begin
							addr[15:0] <= io_din;
						end else begin
							addr[31:16] <= io_din;
							state       <= hps_ext_pkg::stream;
						end
					end
					default: begin
						case (cmd)
							hps_ext_pkg::cmd_dma_write: begin
								hilo <= ~hilo;
								if (!hilo) begin
									wdata_lo <= io_din;
								end else begin
									// high half completes the word, so issue the write
									wdata   <= {io_din, wdata_lo};
									awvalid <= 1'b1;
									wvalid  <= 1'b1;
									busy    <= 1'b1;
								end
							end
							hps_ext_pkg::cmd_dma_read: begin
								hilo <= ~hilo;
								if (!hilo) begin
									arvalid <= 1'b1;
									busy    <= 1'b1;
									state   <= hps_ext_pkg::wait_read;
								end else begin
									io_dout <= rd_hi;
									addr    <= addr + 32'd4;
								end
							end
							hps_ext_pkg::cmd_dma_status: begin
								io_dout    <= hps_ext_pkg::io_word_t'(dma_req);
								dma_status <= io_din[1:0];
							end
							// unknown commands swallow their words
							default: begin
							end
						endcase
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- source/axil_arbiter.sv
`default_nettype none

module axil_arbiter (
	input  wire                      clk_sys,
	input  wire                      rst_n,
	input  hps_ext_pkg::axil_req_t   host_req,
	output hps_ext_pkg::axil_rsp_t   host_rsp,
	input  hps_ext_pkg::axil_req_t   guest_req,
	output hps_ext_pkg::axil_rsp_t   guest_rsp,
	output hps_ext_pkg::axil_req_t   mem_req,
	input  hps_ext_pkg::axil_rsp_t   mem_rsp
);

	// grant_sel is 0 for the host and 1 for the guest
	// it keeps naming the last served master after the grant ends
	logic grant_valid;
	logic grant_sel;
	logic host_ask;
	logic guest_ask;
	logic sel_now;
	logic active;
	logic done;

	assign host_ask  = host_req.awvalid | host_req.arvalid;
	assign guest_ask = guest_req.awvalid | guest_req.arvalid;

	// a fresh request is routed in the same cycle, so the arbiter costs no latency
	always_comb begin
		if (grant_valid) begin
			sel_now = grant_sel;
		end else if (host_ask && guest_ask) begin
			sel_now = ~grant_sel;
		end else begin
			sel_now = guest_ask;
		end
	end

	assign active = grant_valid | host_ask | guest_ask;

	// the master that is not selected sees no ready and no valid at all
	assign mem_req   = !active ? '0 : (sel_now ? guest_req : host_req);
	assign host_rsp  = (active && !sel_now) ? mem_rsp : '0;
	assign guest_rsp = (active && sel_now) ? mem_rsp : '0;

	// the transaction ends on its write or read response handshake
	assign done = active && ((mem_rsp.bvalid && mem_req.bready) ||
		(mem_rsp.rvalid && mem_req.rready));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			grant_valid <= 1'b0;
			// so the host wins the first tie after reset
			grant_sel   <= 1'b1;
		end else if (done) begin
			grant_valid <= 1'b0;
		end else if (!grant_valid && (host_ask || guest_ask)) begin
			grant_valid <= 1'b1;
			grant_sel   <= sel_now;
		end
	end

endmodule

`default_nettype wire

//--- source/axil_word_ram.sv
`default_nettype none

module axil_word_ram #(
	parameter int mem_words = 256
) (
	input  wire                      clk_sys,
	input  wire                      rst_n,
	input  hps_ext_pkg::axil_req_t   mem_req,
	output hps_ext_pkg::axil_rsp_t   mem_rsp
);

	localparam int idx_w = $clog2(mem_words);

	typedef logic [idx_w-1:0] index_t;

	hps_ext_pkg::data_t mem [mem_words];
	logic               aw_held;
	logic               w_held;
	logic               bvalid;
	logic               rvalid;
	index_t             aw_idx;
	hps_ext_pkg::data_t w_data;
	hps_ext_pkg::data_t rdata;
	logic               aw_fire;
	logic               w_fire;
	logic               ar_fire;
	logic               wr_go;

	// word index from the byte address, wrapped at the memory depth
	function automatic index_t to_index(input hps_ext_pkg::addr_t a);
		hps_ext_pkg::addr_t word;
		word = (a >> 2) % hps_ext_pkg::addr_t'(mem_words);
		return index_t'(word);
	endfunction

	// each write channel is taken once and then held until the response goes out
	assign aw_fire = mem_req.awvalid && !aw_held && !bvalid;
	assign w_fire  = mem_req.wvalid && !w_held && !bvalid;
	assign ar_fire = mem_req.arvalid && !rvalid;
	assign wr_go   = aw_held && w_held;

	assign mem_rsp.awready = !aw_held && !bvalid;
	assign mem_rsp.wready  = !w_held && !bvalid;
	assign mem_rsp.bresp   = 2'b00;
	assign mem_rsp.bvalid  = bvalid;
	assign mem_rsp.arready = !rvalid;
	assign mem_rsp.rdata   = rdata;
	assign mem_rsp.rresp   = 2'b00;
	assign mem_rsp.rvalid  = rvalid;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			aw_held <= 1'b0;
			w_held  <= 1'b0;
			bvalid  <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			if (wr_go) begin
				aw_held <= 1'b0;
				w_held  <= 1'b0;
				bvalid  <= 1'b1;
			end else begin
				if (aw_fire) aw_held <= 1'b1;
				if (w_fire) w_held <= 1'b1;
			end
			if (bvalid && mem_req.bready) bvalid <= 1'b0;
			if (ar_fire) begin
				rvalid <= 1'b1;
			end else if (rvalid && mem_req.rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (aw_fire) aw_idx <= to_index(mem_req.awaddr);
		if (w_fire) w_data <= mem_req.wdata;
		if (wr_go) mem[aw_idx] <= w_data;
		if (ar_fire) rdata <= mem[to_index(mem_req.araddr)];
	end

endmodule

`default_nettype wire

//--- source/hps_mem_top.sv
`default_nettype none

module hps_mem_top #(
	parameter int mem_words = 256
) (
	input  wire                      clk_sys,
	input  wire                      rst_n,
	input  hps_ext_pkg::io_word_t    io_din,
	input  wire                      io_strobe,
	input  wire                      io_enable,
	output hps_ext_pkg::io_word_t    io_dout,
	output logic                     dout_en,
	output logic                     busy,
	input  hps_ext_pkg::dma_line_t   dma_req,
	output hps_ext_pkg::dma_line_t   dma_status,
	input  hps_ext_pkg::axil_req_t   guest_req,
	output hps_ext_pkg::axil_rsp_t   guest_rsp
);

	// host side of the arbiter
	hps_ext_pkg::axil_req_t host_req;
	hps_ext_pkg::axil_rsp_t host_rsp;
	// memory side of the arbiter
	hps_ext_pkg::axil_req_t mem_req;
	hps_ext_pkg::axil_rsp_t mem_rsp;

	hps_ext u_hps_ext (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.io_din     (io_din),
		.io_strobe  (io_strobe),
		.io_enable  (io_enable),
		.io_dout    (io_dout),
		.dout_en    (dout_en),
		.busy       (busy),
		.dma_req    (dma_req),
		.dma_status (dma_status),
		.host_req   (host_req),
		.host_rsp   (host_rsp)
	);

	axil_arbiter u_axil_arbiter (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.host_req  (host_req),
		.host_rsp  (host_rsp),
		.guest_req (guest_req),
		.guest_rsp (guest_rsp),
		.mem_req   (mem_req),
		.mem_rsp   (mem_rsp)
	);

	axil_word_ram #(
		.mem_words (mem_words)
	) u_axil_word_ram (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic rst_n
);

	// reset is held low for ten rising edges, then released away from the edge
	initial begin
		clk_sys = 1'b0;
		rst_n   = 1'b0;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
	end

	// eight time units per period
	always #4 clk_sys = ~clk_sys;

endmodule

`default_nettype wire

//--- verification/hps_mem_assertions.sv
`default_nettype none

module hps_mem_assertions (
	input wire                    clk_sys,
	input wire                    rst_n,
	input wire                    busy,
	input hps_ext_pkg::axil_req_t host_req,
	input hps_ext_pkg::axil_rsp_t host_rsp,
	input hps_ext_pkg::axil_req_t mem_req,
	input hps_ext_pkg::axil_rsp_t mem_rsp,
	input hps_ext_pkg::axil_rsp_t guest_rsp
);

	// counts failed assertions for the testbench top to watch
	int   fail_count = 0;
	// the host owns the memory from its address handshake until its response is taken
	logic host_owns;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			host_owns <= 1'b0;
		end else if ((host_rsp.bvalid && host_req.bready) ||
			(host_rsp.rvalid && host_req.rready)) begin
			host_owns <= 1'b0;
		end else if ((host_req.awvalid && host_rsp.awready) ||
			(host_req.arvalid && host_rsp.arready)) begin
			host_owns <= 1'b1;
		end
	end

	// the host master keeps its request valid until the slave takes it
	host_aw_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		host_req.awvalid && !host_rsp.awready |=> host_req.awvalid)
		else begin
			$error("host awvalid dropped before awready");
			fail_count++;
		end

	host_ar_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		host_req.arvalid && !host_rsp.arready |=> host_req.arvalid)
		else begin
			$error("host arvalid dropped before arready");
			fail_count++;
		end

	// the memory holds its responses until they are accepted
	mem_b_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		mem_rsp.bvalid && !mem_req.bready |=> mem_rsp.bvalid)
		else begin
			$error("memory bvalid dropped before bready");
			fail_count++;
		end

	mem_r_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		mem_rsp.rvalid && !mem_req.rready |=> mem_rsp.rvalid)
		else begin
			$error("memory rvalid dropped before rready");
			fail_count++;
		end

	// nothing is outstanding right after reset
	busy_after_reset: assert property (@(posedge clk_sys) $rose(rst_n) |-> !busy)
		else begin
			$error("busy is high right after reset");
			fail_count++;
		end

	// while a host transaction is open the guest must see no response
	guest_quiet: assert property (@(posedge clk_sys) disable iff (!rst_n)
		host_owns |-> !guest_rsp.bvalid && !guest_rsp.rvalid)
		else begin
			$error("guest response valid while the host holds the grant");
			fail_count++;
		end

endmodule

bind hps_mem_top hps_mem_assertions u_assertions (
	.clk_sys   (clk_sys),
	.rst_n     (rst_n),
	.busy      (busy),
	.host_req  (host_req),
	.host_rsp  (host_rsp),
	.mem_req   (mem_req),
	.mem_rsp   (mem_rsp),
	.guest_rsp (guest_rsp)
);

`default_nettype wire

//--- verification/tb_hps_mem.sv
`default_nettype none

module tb_hps_mem;

	localparam int mem_words = 256;
	localparam int stim_size = 512;

	wire                    clk_sys;
	wire                    rst_n;
	hps_ext_pkg::io_word_t  io_din;
	logic                   io_strobe;
	logic                   io_enable;
	hps_ext_pkg::io_word_t  io_dout;
	logic                   dout_en;
	logic                   busy;
	hps_ext_pkg::dma_line_t dma_req;
	hps_ext_pkg::dma_line_t dma_status;
	hps_ext_pkg::axil_req_t guest_req;
	hps_ext_pkg::axil_rsp_t guest_rsp;

	// each record is stored flat as op, address and count followed by count data words
	hps_ext_pkg::data_t stim [stim_size];
	// mirror of the memory that follows every completed write
	hps_ext_pkg::data_t ref_mem [mem_words];
	// addresses to read back after overlapping transfers
	hps_ext_pkg::addr_t touched [$];
	int                 cycles = 0;
	int                 max_cycles = 100;

	tb_clock_gen u_clock_gen (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	hps_mem_top #(
		.mem_words (mem_words)
	) uut (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.io_din     (io_din),
		.io_strobe  (io_strobe),
		.io_enable  (io_enable),
		.io_dout    (io_dout),
		.dout_en    (dout_en),
		.busy       (busy),
		.dma_req    (dma_req),
		.dma_status (dma_status),
		.guest_req  (guest_req),
		.guest_rsp  (guest_rsp)
	);

	task automatic compare_word(input hps_ext_pkg::io_word_t got,
		input hps_ext_pkg::io_word_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
			$display("Verification failed");
			$fatal(1, "stopped at the first wrong host word");
		end
	endtask

	task automatic compare_data(input hps_ext_pkg::data_t got,
		input hps_ext_pkg::data_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
			$display("Verification failed");
			$fatal(1, "stopped at the first wrong memory word");
		end
	endtask

	task automatic compare_line(input hps_ext_pkg::dma_line_t got,
		input hps_ext_pkg::dma_line_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
			$display("Verification failed");
			$fatal(1, "stopped at the first wrong dma line");
		end
	endtask

	task automatic compare_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s expected %b got %b", $time, what, exp, got);
			$display("Verification failed");
			$fatal(1, "stopped at the first wrong flag");
		end
	endtask

	task automatic compare_resp(input logic [1:0] got, input logic [1:0] exp,
		input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s expected %b got %b", $time, what, exp, got);
			$display("Verification failed");
			$fatal(1, "stopped at the first wrong response code");
		end
	endtask

	// maps a byte address to its word slot and wraps at the memory depth
	function automatic int word_index(input hps_ext_pkg::addr_t a);
		return int'((a / 4) % mem_words);
	endfunction

	// every host task starts and ends on a falling edge
	task automatic host_strobe(input hps_ext_pkg::io_word_t word);
		io_din    = word;
		io_strobe = 1'b1;
		@(negedge clk_sys);
		io_strobe = 1'b0;
		// no further strobe while a memory transaction is outstanding
		while (busy) @(negedge clk_sys);
	endtask

	// a strobe that starts a memory access must raise busy in the following cycle
	task automatic host_strobe_access(input hps_ext_pkg::io_word_t word, input string what);
		io_din    = word;
		io_strobe = 1'b1;
		@(negedge clk_sys);
		io_strobe = 1'b0;
		compare_flag(busy, 1'b1, what);
		while (busy) @(negedge clk_sys);
	endtask

	task automatic host_command(input hps_ext_pkg::io_word_t cmd, input logic known);
		io_enable = 1'b1;
		host_strobe(cmd);
		compare_flag(dout_en, known, "dout_en after the command word");
	endtask

	task automatic host_release();
		io_enable = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic host_block_write(input hps_ext_pkg::addr_t a, input int first, input int count);
		hps_ext_pkg::addr_t cur;
		hps_ext_pkg::data_t w;
		cur = a;
		host_command(hps_ext_pkg::cmd_dma_write, 1'b1);
		host_strobe(a[15:0]);
		host_strobe(a[31:16]);
		for (int i = 0; i < count; i++) begin
			w = stim[first + i];
			host_strobe(w[15:0]);
			host_strobe_access(w[31:16], "busy after the high half of a block write");
			// busy has fallen again, so the word sits in memory
			ref_mem[word_index(cur)] = w;
			cur = cur + 32'd4;
		end
		host_release();
	endtask

	task automatic host_block_read(input hps_ext_pkg::addr_t a, input int first, input int count);
		hps_ext_pkg::data_t exp;
		host_command(hps_ext_pkg::cmd_dma_read, 1'b1);
		host_strobe(a[15:0]);
		host_strobe(a[31:16]);
		for (int i = 0; i < count; i++) begin
			exp = stim[first + i];
			host_strobe_access('0, "busy after a block read strobe");
			compare_word(io_dout, exp[15:0], "low half of a block read");
			host_strobe('0);
			compare_word(io_dout, exp[31:16], "high half of a block read");
		end
		host_release();
	endtask

	task automatic host_status(input int first, input int count);
		hps_ext_pkg::data_t w;
		host_command(hps_ext_pkg::cmd_dma_status, 1'b1);
		for (int i = 0; i < count; i++) begin
			// bits 17:16 of the record word are the dma_req lines to present
			w       = stim[first + i];
			dma_req = w[17:16];
			host_strobe(w[15:0]);
			compare_word(io_dout, hps_ext_pkg::io_word_t'(w[17:16]), "dma_req on io_dout");
			compare_line(dma_status, w[1:0], "dma_status pulse");
			compare_flag(dout_en, 1'b1, "dout_en during status exchange");
			@(negedge clk_sys);
			compare_line(dma_status, '0, "dma_status one cycle after its pulse");
		end
		host_release();
	endtask

	// responses are sampled two time units after the falling edge once the arbiter routes them
	task automatic guest_write(input hps_ext_pkg::addr_t a, input hps_ext_pkg::data_t d);
		logic aw_left;
		logic w_left;
		logic b_seen;
		guest_req.awaddr  = a;
		guest_req.wdata   = d;
		guest_req.awvalid = 1'b1;
		guest_req.wvalid  = 1'b1;
		aw_left = 1'b1;
		w_left  = 1'b1;
		b_seen  = 1'b0;
		while (!b_seen) begin
			#2;
			b_seen  = guest_rsp.bvalid;
			aw_left = aw_left && !guest_rsp.awready;
			w_left  = w_left && !guest_rsp.wready;
			if (b_seen) begin
				compare_resp(guest_rsp.bresp, 2'b00, "bresp of a guest write");
			end
			@(negedge clk_sys);
			guest_req.awvalid = aw_left;
			guest_req.wvalid  = w_left;
		end
		ref_mem[word_index(a)] = d;
	endtask

	task automatic guest_read(input hps_ext_pkg::addr_t a, output hps_ext_pkg::data_t d);
		logic ar_left;
		logic r_seen;
		guest_req.araddr  = a;
		guest_req.arvalid = 1'b1;
		ar_left = 1'b1;
		r_seen  = 1'b0;
		d       = '0;
		while (!r_seen) begin
			#2;
			r_seen  = guest_rsp.rvalid;
			d       = guest_rsp.rdata;
			ar_left = ar_left && !guest_rsp.arready;
			if (r_seen) begin
				compare_resp(guest_rsp.rresp, 2'b00, "rresp of a guest read");
			end
			@(negedge clk_sys);
			guest_req.arvalid = ar_left;
		end
	endtask

	task automatic read_and_check(input hps_ext_pkg::addr_t a, input hps_ext_pkg::data_t exp,
		input string what);
		hps_ext_pkg::data_t got;
		guest_read(a, got);
		compare_data(got, exp, what);
	endtask

	task automatic guest_random_writes(input int count);
		hps_ext_pkg::addr_t a;
		hps_ext_pkg::data_t d;
		// random start so the guest lands at a different point of the host stream
		repeat ($urandom % 12) @(negedge clk_sys);
		for (int i = 0; i < count; i++) begin
			a = hps_ext_pkg::addr_t'(($urandom % mem_words) * 4);
			d = $urandom;
			guest_write(a, d);
			touched.push_back(a);
		end
	endtask

	task automatic overlapping_writes(input hps_ext_pkg::addr_t a, input int first, input int count);
		touched.delete();
		for (int i = 0; i < count; i++) begin
			touched.push_back(a + hps_ext_pkg::addr_t'(4 * i));
		end
		fork
			host_block_write(a, first, count);
			guest_random_writes(count);
		join
		foreach (touched[i]) begin
			read_and_check(touched[i], ref_mem[word_index(touched[i])],
				"read back after overlapping transfers");
		end
	endtask

	task automatic unknown_command(input hps_ext_pkg::addr_t a, input int first, input int count);
		host_command(stim[first][15:0], 1'b0);
		for (int i = 1; i < count; i++) begin
			host_strobe(stim[first + i][15:0]);
			compare_flag(dout_en, 1'b0, "dout_en during an unknown command");
		end
		host_release();
		read_and_check(a, ref_mem[word_index(a)], "memory word after an unknown command");
	endtask

	task automatic restart_write(input hps_ext_pkg::addr_t a, input int first, input int count);
		// a write is abandoned after half its address, then sent again in full
		host_command(hps_ext_pkg::cmd_dma_write, 1'b1);
		host_strobe(~a[15:0]);
		host_release();
		host_block_write(a, first, count);
		for (int i = 0; i < count; i++) begin
			read_and_check(a + hps_ext_pkg::addr_t'(4 * i), stim[first + i],
				"word written after a restarted transfer");
		end
	endtask

	// the watchdog and the assertion monitor run once per cycle
	always @(negedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > max_cycles) begin
			$display("Verification failed");
			$fatal(1, "timeout, the records did not finish within %0d cycles", max_cycles);
		end else if (uut.u_assertions.fail_count != 0) begin
			$display("Verification failed");
			$fatal(1, "a protocol assertion failed");
		end
	end

	initial begin
		int p;
		int records;
		int op;
		int n;
		hps_ext_pkg::addr_t a;
		void'($urandom(32'he874));
		io_din    = '0;
		io_strobe = 1'b0;
		io_enable = 1'b0;
		dma_req   = '0;
		guest_req = '0;
		// the guest always takes its responses at once and writes whole words
		guest_req.wstrb  = 4'hf;
		guest_req.bready = 1'b1;
		guest_req.rready = 1'b1;
		$readmemh("verification/stimulus_input.txt", stim);
		p       = 0;
		records = 0;
		while (stim[p] != 0) begin
			records = records + 1;
			p = p + 3 + int'(stim[p + 2]);
		end
		if (records == 0) begin
			$display("Verification failed");
			$fatal(1, "the stimulus file holds no records");
		end
		max_cycles = 200 * records + 100;
		wait (rst_n === 1'b1);
		@(negedge clk_sys);
		compare_flag(busy, 1'b0, "busy after reset");
		compare_flag(dout_en, 1'b0, "dout_en after reset");
		compare_word(io_dout, '0, "io_dout after reset");
		compare_line(dma_status, '0, "dma_status after reset");
		p = 0;
		while (stim[p] != 0) begin
			op = int'(stim[p]);
			a  = stim[p + 1];
			n  = int'(stim[p + 2]);
			case (op)
				1: begin
					host_block_write(a, p + 3, n);
					for (int i = 0; i < n; i++) begin
						read_and_check(a + hps_ext_pkg::addr_t'(4 * i), stim[p + 3 + i],
							"guest read after a host block write");
					end
				end
				2: begin
					for (int i = 0; i < n; i++) begin
						guest_write(a + hps_ext_pkg::addr_t'(4 * i), stim[p + 3 + i]);
					end
					host_block_read(a, p + 3, n);
				end
				3: host_status(p + 3, n);
				4: overlapping_writes(a, p + 3, n);
				5: unknown_command(a, p + 3, n);
				6: restart_write(a, p + 3, n);
				default: begin
					$display("Verification failed");
					$fatal(1, "the stimulus file names an unknown operation %0d", op);
				end
			endcase
			p = p + 3 + n;
		end
		repeat (4) @(negedge clk_sys);
		if (uut.u_assertions.fail_count != 0) begin
			$display("Verification failed");
			$fatal(1, "a protocol assertion failed");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verification/stimulus_input.txt
// columns: op, byte address, word count, then that many data words, all hex; op 0 ends the list
// op 1 host write, 2 guest write then host read, 3 status, 4 overlap, 5 unknown, 6 restart
1 00000010 4 11112222 33334444 55556666 77778888
// this block runs past the last word and wraps to word 0
1 000003f8 4 a1b2c3d4 0f1e2d3c 89abcdef 13572468
2 00000100 3 deadbeef 00000001 fedcba98
2 000000f0 2 5a5aa5a5 c0ffee00
// status words carry dma_req in bits 17:16 and the host word below
3 00000000 4 00010003 00020001 00030002 00000000
4 00000200 4 01010101 02020202 03030303 04040404
4 00000020 3 aaaa5555 12345678 9abcdef0
// the first word is the unknown command, the address is the word that must not change
5 00000010 5 00000055 00000010 00000000 0000dead 0000beef
5 00000014 3 00000000 00000014 00000000
6 00000040 2 cafef00d 0badc0de
0 00000000 0

//--- tb.f
source/hps_ext_pkg.sv
source/hps_ext.sv
source/axil_arbiter.sv
source/axil_word_ram.sv
source/hps_mem_top.sv
verification/tb_clock_gen.sv
verification/hps_mem_assertions.sv
verification/tb_hps_mem.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_hps_mem
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
SIM_ARGS   ?= +verilator+error+limit+10

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
